// ==== vlog.f ====
+incdir+hw
hw/uarc_int_pkg.sv
hw/vector_table.sv
hw/send_arbiter.sv
hw/int_dispatcher.sv
hw/uarc_int_unit.sv
tests/uarc_int_chk.sv
tests/uarc_int_monitor.sv
tests/uarc_int_tb.sv

// ==== Bender.yml ====
package:
  name: uarc_int

export_include_dirs:
  - hw

sources:
  - files:
      - hw/uarc_int_pkg.sv
      - hw/vector_table.sv
      - hw/send_arbiter.sv
      - hw/int_dispatcher.sv
      - hw/uarc_int_unit.sv
  - target: test
    files:
      - tests/uarc_int_chk.sv
      - tests/uarc_int_monitor.sv
      - tests/uarc_int_tb.sv

// ==== tests/uarc_int_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uarc_int_cfg.svh"

module uarc_int_tb;

  typedef struct packed {
    uarc_int_pkg::cfg_op_t   op;
    uarc_int_pkg::bus_idx_t  bus;
    uarc_int_pkg::word_t     value;
    uarc_int_pkg::bus_mask_t mask;
    logic [7:0]              ack_delay;
    logic [3:0]              dispatches;
  } entry_t;

  localparam int num_entries = 14;
  localparam int reset_cycles = 16;
  localparam int cycle_limit = reset_cycles + num_entries * 40;

  // Columns: config op, config bus, config value, sends, core ack delay, dispatches
  localparam entry_t entries [num_entries] = '{
    '{uarc_int_pkg::CFG_SET_ENABLES, 3'd0, 32'h0000_0000, 8'h04, 8'd0, 4'd0},
    '{uarc_int_pkg::CFG_SET_VECTOR, 3'd0, 32'h0000_0100, 8'h00, 8'd0, 4'd0},
    '{uarc_int_pkg::CFG_SET_VECTOR, 3'd2, 32'h0000_02a4, 8'h00, 8'd0, 4'd0},
    '{uarc_int_pkg::CFG_SET_VECTOR, 3'd3, 32'h0000_0333, 8'h00, 8'd0, 4'd0},
    '{uarc_int_pkg::CFG_SET_VECTOR, 3'd5, 32'h0000_05c5, 8'h00, 8'd0, 4'd0},
    '{uarc_int_pkg::CFG_SET_VECTOR, 3'd7, 32'h0000_07f0, 8'h00, 8'd0, 4'd0},
    '{uarc_int_pkg::CFG_SET_ENABLES, 3'd0, 32'h0000_00ad, 8'h00, 8'd0, 4'd0},
    '{uarc_int_pkg::CFG_NONE, 3'd0, 32'h0000_0000, 8'h04, 8'd1, 4'd1},
    '{uarc_int_pkg::CFG_NONE, 3'd0, 32'h0000_0000, 8'hff, 8'd2, 4'd5},
    '{uarc_int_pkg::CFG_SET_VECTOR, 3'd2, 32'hffff_fabc, 8'h00, 8'd0, 4'd0},
    '{uarc_int_pkg::CFG_NONE, 3'd0, 32'h0000_0000, 8'h04, 8'd0, 4'd1},
    '{uarc_int_pkg::CFG_NONE, 3'd0, 32'h0000_0000, 8'h20, 8'd12, 4'd1},
    '{uarc_int_pkg::CFG_NONE, 3'd0, 32'h0000_0000, 8'h81, 8'd20, 4'd2},
    '{uarc_int_pkg::CFG_NONE, 3'd0, 32'h0000_0000, 8'h12, 8'd0, 4'd0}
  };

  logic                                        clk = 1'b0;
  logic                                        reset = 1'b1;
  uarc_int_pkg::cfg_op_t                       cfg_op = uarc_int_pkg::CFG_NONE;
  uarc_int_pkg::bus_idx_t                      cfg_bus = '0;
  uarc_int_pkg::word_t                         cfg_value = '0;
  uarc_int_pkg::bus_mask_t                     sends = '0;
  uarc_int_pkg::word_t [`UARC_TOTAL_BUSES-1:0] datas = '0;
  logic                                        dispatch_ack = 1'b0;
  uarc_int_pkg::bus_mask_t                     send_acks;
  logic                                        dispatch_req;
  uarc_int_pkg::bus_idx_t                      dispatch_bus;
  uarc_int_pkg::prog_addr_t                    dispatch_addr;
  uarc_int_pkg::word_t                         dispatch_data;

  uarc_int_pkg::bus_mask_t raise_mask = '0;
  logic                    clear_sends = 1'b0;
  logic [7:0]              ack_delay = '0;
  logic [7:0]              ack_wait = '0;
  int                      done_count = 0;
  int                      cycle_count = 0;
  int                      expected_dispatches = 0;
  logic                    entry_check = 1'b0;
  int                      monitor_errors;
  int                      chk_failures;
  logic [31:0]             rng = 32'h2e377f87;

  uarc_int_unit uarc_int_unit_inst (
    .clk (clk), .reset (reset),
    .cfg_op (cfg_op), .cfg_bus (cfg_bus), .cfg_value (cfg_value),
    .sends (sends), .datas (datas), .send_acks (send_acks),
    .dispatch_req (dispatch_req), .dispatch_bus (dispatch_bus),
    .dispatch_addr (dispatch_addr), .dispatch_data (dispatch_data),
    .dispatch_ack (dispatch_ack)
  );

  uarc_int_monitor uarc_int_monitor_inst (
    .clk (clk), .reset (reset),
    .cfg_op (cfg_op), .cfg_bus (cfg_bus), .cfg_value (cfg_value),
    .sends (sends), .datas (datas), .send_acks (send_acks),
    .dispatch_req (dispatch_req), .dispatch_bus (dispatch_bus),
    .dispatch_addr (dispatch_addr), .dispatch_data (dispatch_data),
    .dispatch_ack (dispatch_ack), .entry_check (entry_check),
    .expected_dispatches (expected_dispatches), .error_count (monitor_errors)
  );

  bind int_dispatcher uarc_int_chk uarc_int_chk_inst (
    .clk (clk), .reset (reset), .dispatch_req (dispatch_req),
    .dispatch_ack (dispatch_ack), .dispatch_bus (dispatch_bus),
    .dispatch_addr (dispatch_addr), .dispatch_data (dispatch_data),
    .send_acks (send_acks)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // Senders drop a request once its ack is seen and count each finished handshake
  always @(posedge clk) begin
    if (reset || clear_sends) begin
      sends <= '0;
    end else begin
      sends <= (sends & ~send_acks) | raise_mask;
      done_count <= done_count + $countones(sends & send_acks);
    end
  end

  // Core side waits the entry's delay before acknowledging
  always @(posedge clk) begin
    if (reset) begin
      dispatch_ack <= 1'b0;
      ack_wait <= '0;
    end else if (dispatch_req && !dispatch_ack) begin
      if (ack_wait >= ack_delay) begin
        dispatch_ack <= 1'b1;
        ack_wait <= '0;
      end else begin
        ack_wait <= ack_wait + 8'd1;
      end
    end else if (!dispatch_req && dispatch_ack) begin
      dispatch_ack <= 1'b0;
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  task automatic apply_entry(input entry_t ent);
    int base;
    cfg_op <= ent.op;
    cfg_bus <= ent.bus;
    cfg_value <= ent.value;
    @(posedge clk);
    cfg_op <= uarc_int_pkg::CFG_NONE;
    if (ent.mask != '0) begin
      for (int b = 0; b < `UARC_TOTAL_BUSES; b++) begin
        rng = xorshift32(rng);
        datas[b] <= rng;
      end
      ack_delay <= ent.ack_delay;
      base = done_count;
      raise_mask <= ent.mask;
      @(posedge clk);
      raise_mask <= '0;
      if (ent.dispatches == 0) begin
        repeat (10) @(posedge clk);
      end else begin
        while (done_count != base + int'(ent.dispatches) || send_acks != '0) begin
          @(posedge clk);
        end
      end
      // Disabled buses never get an ack, so their requests are withdrawn here
      clear_sends <= 1'b1;
      @(posedge clk);
      clear_sends <= 1'b0;
    end
    repeat (3) @(posedge clk);
    expected_dispatches <= int'(ent.dispatches);
    entry_check <= 1'b1;
    @(posedge clk);
    entry_check <= 1'b0;
  endtask

  initial begin
    repeat (reset_cycles) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    for (int e = 0; e < num_entries; e++) begin
      apply_entry(entries[e]);
    end
    repeat (4) @(posedge clk);
    chk_failures = uarc_int_unit_inst.int_dispatcher_inst.uarc_int_chk_inst.assert_failures;
    uarc_int_monitor_inst.print_summary(chk_failures);
    if (monitor_errors == 0 && chk_failures == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/uarc_int_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uarc_int_cfg.svh"

// Mirrors the configuration and checks every dispatch against the priority rule
module uarc_int_monitor (
  input  wire                                          clk,
  input  wire                                          reset,
  input  uarc_int_pkg::cfg_op_t                        cfg_op,
  input  uarc_int_pkg::bus_idx_t                       cfg_bus,
  input  uarc_int_pkg::word_t                          cfg_value,
  input  uarc_int_pkg::bus_mask_t                      sends,
  input  uarc_int_pkg::word_t [`UARC_TOTAL_BUSES-1:0]  datas,
  input  uarc_int_pkg::bus_mask_t                      send_acks,
  input  wire                                          dispatch_req,
  input  uarc_int_pkg::bus_idx_t                       dispatch_bus,
  input  uarc_int_pkg::prog_addr_t                     dispatch_addr,
  input  uarc_int_pkg::word_t                          dispatch_data,
  input  wire                                          dispatch_ack,
  input  wire                                          entry_check,
  input  int                                           expected_dispatches,
  output int                                           error_count
);

  uarc_int_pkg::bus_mask_t  enables;
  uarc_int_pkg::prog_addr_t vectors [`UARC_TOTAL_BUSES];
  uarc_int_pkg::bus_mask_t  masked;
  uarc_int_pkg::bus_mask_t  masked_prev;
  uarc_int_pkg::bus_mask_t  sends_prev;
  uarc_int_pkg::bus_mask_t  acks_prev;
  uarc_int_pkg::bus_idx_t   served_bus;
  logic req_prev;
  logic txn_open;
  logic timing_armed;
  logic first_sample;
  int   cycle;
  int   armed_cycle;
  int   dispatches;
  int   entry_dispatches;
  int   pick;

  function automatic int lowest_bus(input uarc_int_pkg::bus_mask_t m);
    for (int i = 0; i < `UARC_TOTAL_BUSES; i++) begin
      if (m[i]) begin
        return i;
      end
    end
    return -1;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (expected !== actual) begin
      error_count = error_count + 1;
      $display("** Error: %s expected %h got %h", name, expected, actual);
    end
  endtask

  task automatic report_failure(input string what);
    error_count = error_count + 1;
    $display("Failure: %s", what);
  endtask

  task print_summary(input int assert_failures);
    $display("Summary: %0d dispatches checked, %0d compare errors, %0d assertion failures",
             dispatches, error_count, assert_failures);
  endtask

  always @(posedge clk) begin
    if (reset) begin
      enables = '0;
      for (int i = 0; i < `UARC_TOTAL_BUSES; i++) begin
        vectors[i] = '0;
      end
      masked_prev = '0;
      sends_prev = '0;
      acks_prev = '0;
      served_bus = '0;
      req_prev = 1'b0;
      txn_open = 1'b0;
      timing_armed = 1'b0;
      first_sample = 1'b1;
      cycle = 0;
      dispatches = 0;
      entry_dispatches = 0;
      error_count = 0;
    end else begin
      cycle = cycle + 1;
      masked = sends & enables;
      if (first_sample && (dispatch_req || send_acks != '0)) begin
        report_failure("dispatch_req or send_acks high right after reset");
      end
      first_sample = 1'b0;
      // A fresh request on an idle unit must reach the core in 2 cycles
      if (masked != '0 && masked_prev == '0 && !txn_open) begin
        timing_armed = 1'b1;
        armed_cycle = cycle;
      end
      if (dispatch_req && !req_prev) begin
        dispatches = dispatches + 1;
        entry_dispatches = entry_dispatches + 1;
        pick = lowest_bus(masked);
        if (pick < 0) begin
          report_failure("dispatch_req rose with no enabled bus pending");
        end else begin
          compare_value("dispatch_bus", pick, dispatch_bus);
          compare_value("dispatch_addr", vectors[pick], dispatch_addr);
          compare_value("dispatch_data", datas[pick], dispatch_data);
          served_bus = uarc_int_pkg::bus_idx_t'(pick);
        end
        if (timing_armed) begin
          compare_value("dispatch_req latency", 2, cycle - armed_cycle);
        end
        timing_armed = 1'b0;
        txn_open = 1'b1;
      end
      if ((dispatch_req || dispatch_ack) && send_acks != '0) begin
        report_failure("send_acks rose before the core handshake completed");
      end
      if (send_acks != '0) begin
        compare_value("send_acks", uarc_int_pkg::bus_mask_t'(1) << served_bus, send_acks);
      end
      if (send_acks == '0 && acks_prev != '0) begin
        txn_open = 1'b0;
        // The unit may only drop its ack after it has seen the request low
        if (sends_prev[served_bus]) begin
          report_failure("send_acks fell before the sender's request was seen low");
        end
      end
      if (entry_check) begin
        compare_value("dispatch_req count", expected_dispatches, entry_dispatches);
        entry_dispatches = 0;
      end
      // The DUT takes configuration on this edge, so the mirror follows after the checks
      if (cfg_op == uarc_int_pkg::CFG_SET_ENABLES) begin
        enables = cfg_value[`UARC_TOTAL_BUSES-1:0];
      end else if (cfg_op == uarc_int_pkg::CFG_SET_VECTOR) begin
        vectors[cfg_bus] = cfg_value[`UARC_PROG_ADDR_WIDTH-1:0];
      end
      req_prev = dispatch_req;
      acks_prev = send_acks;
      sends_prev = sends;
      masked_prev = masked;
    end
  end

endmodule

`default_nettype wire

// ==== tests/uarc_int_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uarc_int_cfg.svh"

// Handshake properties checked inside int_dispatcher through bind
module uarc_int_chk (
  input  wire                       clk,
  input  wire                       reset,
  input  wire                       dispatch_req,
  input  wire                       dispatch_ack,
  input  uarc_int_pkg::bus_idx_t    dispatch_bus,
  input  uarc_int_pkg::prog_addr_t  dispatch_addr,
  input  uarc_int_pkg::word_t       dispatch_data,
  input  uarc_int_pkg::bus_mask_t   send_acks
);

  int assert_failures = 0;

  // The core must have acknowledged before the request is withdrawn
  req_waits_for_ack: assert property (@(posedge clk) disable iff (reset)
    $fell(dispatch_req) |-> $past(dispatch_ack))
    else begin
      assert_failures = assert_failures + 1;
      $error("dispatch_req fell before dispatch_ack was seen");
    end

  payload_stable: assert property (@(posedge clk) disable iff (reset)
    dispatch_req && $past(dispatch_req) |->
      $stable(dispatch_bus) && $stable(dispatch_addr) && $stable(dispatch_data))
    else begin
      assert_failures = assert_failures + 1;
      $error("dispatch payload changed while dispatch_req was high");
    end

  // A sender ack stays on a single bus and waits until the core side is quiet
  sender_ack_after_core: assert property (@(posedge clk) disable iff (reset)
    send_acks != '0 |-> $onehot(send_acks) && !dispatch_req && !dispatch_ack)
    else begin
      assert_failures = assert_failures + 1;
      $error("send_acks high on more than one bus or during the core handshake");
    end

endmodule

`default_nettype wire

// ==== hw/uarc_int_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uarc_int_cfg.svh"

// Standalone bus-interrupt intake of the UARC core
module uarc_int_unit (
  input  wire                                          clk,
  input  wire                                          reset,

  // Configuration, one command per cycle
  input  uarc_int_pkg::cfg_op_t                        cfg_op,
  input  uarc_int_pkg::bus_idx_t                       cfg_bus,
  input  uarc_int_pkg::word_t                          cfg_value,

  // Receiver side, four-phase per bus
  input  uarc_int_pkg::bus_mask_t                      sends,
  input  uarc_int_pkg::word_t [`UARC_TOTAL_BUSES-1:0]  datas,
  output uarc_int_pkg::bus_mask_t                      send_acks,

  // Core side, four-phase
  output logic                                         dispatch_req,
  output uarc_int_pkg::bus_idx_t                       dispatch_bus,
  output uarc_int_pkg::prog_addr_t                     dispatch_addr,
  output uarc_int_pkg::word_t                          dispatch_data,
  input  wire                                          dispatch_ack
);

  logic                     choice_valid;
  uarc_int_pkg::bus_idx_t   choice_bus;
  uarc_int_pkg::prog_addr_t choice_vector;
  logic                     busy;

  send_arbiter send_arbiter_inst (
    .clk          (clk),
    .reset        (reset),
    .cfg_op       (cfg_op),
    .cfg_value    (cfg_value),
    .sends        (sends),
    .busy         (busy),
    .choice_valid (choice_valid),
    .choice_bus   (choice_bus)
  );

  vector_table vector_table_inst (
    .clk           (clk),
    .reset         (reset),
    .cfg_op        (cfg_op),
    .cfg_bus       (cfg_bus),
    .cfg_value     (cfg_value),
    .choice_bus    (choice_bus),
    .choice_vector (choice_vector)
  );

  int_dispatcher int_dispatcher_inst (
    .clk           (clk),
    .reset         (reset),
    .choice_valid  (choice_valid),
    .choice_bus    (choice_bus),
    .choice_vector (choice_vector),
    .datas         (datas),
    .sends         (sends),
    .dispatch_ack  (dispatch_ack),
    .busy          (busy),
    .send_acks     (send_acks),
    .dispatch_req  (dispatch_req),
    .dispatch_bus  (dispatch_bus),
    .dispatch_addr (dispatch_addr),
    .dispatch_data (dispatch_data)
  );

endmodule

`default_nettype wire

// ==== hw/int_dispatcher.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uarc_int_cfg.svh"

// Hands the chosen interrupt to the core side, then acknowledges the sender
module int_dispatcher (
  input  wire                                          clk,
  input  wire                                          reset,
  input  wire                                          choice_valid,
  input  uarc_int_pkg::bus_idx_t                       choice_bus,
  input  uarc_int_pkg::prog_addr_t                     choice_vector,
  input  uarc_int_pkg::word_t [`UARC_TOTAL_BUSES-1:0]  datas,
  input  uarc_int_pkg::bus_mask_t                      sends,
  input  wire                                          dispatch_ack,
  output logic                                         busy,
  output uarc_int_pkg::bus_mask_t                      send_acks,
  output logic                                         dispatch_req,
  output uarc_int_pkg::bus_idx_t                       dispatch_bus,
  output uarc_int_pkg::prog_addr_t                     dispatch_addr,
  output uarc_int_pkg::word_t                          dispatch_data
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_REQUEST,
    ST_RELEASE,
    ST_ACK_SENDER,
    ST_WAIT_DROP
  } state_t;

  state_t state;

  logic start;
  logic sender_req;
  logic acking;

  // The arbiter choice can be stale for a cycle after a dispatch ends,
  // so the sender's request must still be up before we take it
  assign start = choice_valid && sends[choice_bus];

  assign sender_req = sends[dispatch_bus];

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (start) begin
            state <= ST_REQUEST;
          end
        end
        ST_REQUEST: begin
          if (dispatch_ack) begin
            state <= ST_RELEASE;
          end
        end
        ST_RELEASE: begin
          // Core side is done only once its ack is low again
          if (!dispatch_ack) begin
            state <= ST_ACK_SENDER;
          end
        end
        // First cycle of the sender ack, the sender has not reacted yet
        ST_ACK_SENDER: state <= ST_WAIT_DROP;
        ST_WAIT_DROP: begin
          if (!sender_req) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Payload is captured once and held through both handshakes
  always_ff @(posedge clk) begin
    if (state == ST_IDLE && start) begin
      dispatch_bus <= choice_bus;
      dispatch_addr <= choice_vector;
      dispatch_data <= datas[choice_bus];
    end
  end

  assign busy = state != ST_IDLE;
  assign dispatch_req = state == ST_REQUEST;
  assign acking = state == ST_ACK_SENDER || state == ST_WAIT_DROP;

  // Only the captured bus ever sees its ack
  assign send_acks = acking ? uarc_int_pkg::bus_mask_t'(1) << dispatch_bus : '0;

endmodule

`default_nettype wire

// ==== hw/send_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uarc_int_cfg.svh"

// Enable masking and lowest-index selection of pending sends
module send_arbiter (
  input  wire                     clk,
  input  wire                     reset,
  input  uarc_int_pkg::cfg_op_t   cfg_op,
  input  uarc_int_pkg::word_t     cfg_value,
  input  uarc_int_pkg::bus_mask_t sends,
  input  wire                     busy,
  output logic                    choice_valid,
  output uarc_int_pkg::bus_idx_t  choice_bus
);

  uarc_int_pkg::bus_mask_t enables;
  uarc_int_pkg::bus_mask_t masked_sends;
  uarc_int_pkg::bus_idx_t  pick_bus;
  logic                    pick_valid;

  always_ff @(posedge clk) begin
    if (reset) begin
      enables <= '0;
    end else if (cfg_op == uarc_int_pkg::CFG_SET_ENABLES) begin
      enables <= cfg_value[`UARC_TOTAL_BUSES-1:0];
    end
  end

  assign masked_sends = sends & enables;

  // Scanning downward lets the lowest pending bus overwrite the others,
  // matching the core's priority encoder
  always_comb begin
    pick_valid = |masked_sends;
    pick_bus = '0;
    for (int i = `UARC_TOTAL_BUSES - 1; i >= 0; i--) begin
      if (masked_sends[i]) begin
        pick_bus = uarc_int_pkg::bus_idx_t'(i);
      end
    end
  end

  // The choice stays frozen for the whole dispatch so the vector
  // lookup keeps pointing at the bus being served
  always_ff @(posedge clk) begin
    if (reset) begin
      choice_valid <= 1'b0;
      choice_bus <= '0;
    end else if (!busy) begin
      choice_valid <= pick_valid;
      choice_bus <= pick_bus;
    end
  end

endmodule

`default_nettype wire

// ==== hw/vector_table.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uarc_int_cfg.svh"

// Interrupt vector per bus, the standalone form of the core's ISET table
module vector_table (
  input  wire                       clk,
  input  wire                       reset,
  input  uarc_int_pkg::cfg_op_t     cfg_op,
  input  uarc_int_pkg::bus_idx_t    cfg_bus,
  input  uarc_int_pkg::word_t       cfg_value,
  input  uarc_int_pkg::bus_idx_t    choice_bus,
  output uarc_int_pkg::prog_addr_t  choice_vector
);

  uarc_int_pkg::prog_addr_t [`UARC_TOTAL_BUSES-1:0] vectors;

  logic write_en;

  assign write_en = cfg_op == uarc_int_pkg::CFG_SET_VECTOR;

  // A new vector lands on the edge after the command is seen
  always_ff @(posedge clk) begin
    if (reset) begin
      vectors <= '0;
    end else if (write_en) begin
      vectors[cfg_bus] <= cfg_value[`UARC_PROG_ADDR_WIDTH-1:0];
    end
  end

  // Combinational read for whichever bus the arbiter currently holds
  assign choice_vector = vectors[choice_bus];

endmodule

`default_nettype wire

// ==== hw/uarc_int_pkg.sv ====
`default_nettype none

`include "uarc_int_cfg.svh"

package uarc_int_pkg;

  typedef logic [`UARC_WORD_WIDTH-1:0] word_t;

  typedef logic [`UARC_PROG_ADDR_WIDTH-1:0] prog_addr_t;

  typedef logic [`UARC_BUS_IDX_WIDTH-1:0] bus_idx_t;

  // One bit per bus, bit i belongs to bus i
  typedef logic [`UARC_TOTAL_BUSES-1:0] bus_mask_t;

  // Configuration commands, sampled every cycle without a handshake
  typedef enum logic [1:0] {
    CFG_NONE        = 2'd0,
    // Low bits of the value replace the whole enable mask
    CFG_SET_ENABLES = 2'd1,
    // Low bits of the value become the vector of the addressed bus
    CFG_SET_VECTOR  = 2'd2
  } cfg_op_t;

endpackage

`default_nettype wire

// ==== hw/uarc_int_cfg.svh ====
`ifndef UARC_INT_CFG_SVH
`define UARC_INT_CFG_SVH

// Number of receive buses feeding the interrupt intake
`define UARC_TOTAL_BUSES 8

// Width of one data word carried by a send
`define UARC_WORD_WIDTH 32

// Width of a program address, which is what a vector holds
`define UARC_PROG_ADDR_WIDTH 12

// Bits needed to number every bus
`define UARC_BUS_IDX_WIDTH $clog2(`UARC_TOTAL_BUSES)

`endif
